// File: logic/audio_pkg.sv
// Shared widths, compressor curve constants and register map of the audio mixer
// Samples are signed 16-bit throughout, compressor math is unsigned 16-bit
`default_nettype none

package audio_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sample datapath
	localparam int sample_w = 16;
	localparam int mix_w    = sample_w + 2;   // Two guard bits for the summation

	// Soft-knee compressor, 2x curve
	localparam logic [sample_w-1:0] comp_a_2x = 16'd2;
	localparam logic [sample_w-1:0] comp_f_2x = 16'd4;
	localparam logic [sample_w-1:0] comp_x_2x = 16'd14043;   // Knee
	localparam logic [sample_w-1:0] comp_b_2x = 16'd28086;   // Output level at the knee

	// Soft-knee compressor, 4x curve
	localparam logic [sample_w-1:0] comp_a_4x = 16'd4;
	localparam logic [sample_w-1:0] comp_f_4x = 16'd8;
	localparam logic [sample_w-1:0] comp_x_4x = 16'd7399;
	localparam logic [sample_w-1:0] comp_b_4x = 16'd29596;

	////////////////////////////////////////////////////////////////////////////
	// AXI4-Lite register map
	localparam int axil_addr_w = 4;
	localparam int axil_data_w = 32;

	localparam logic [axil_addr_w-1:0] reg_ctrl_addr  = 4'h0;
	localparam logic [axil_addr_w-1:0] reg_count_addr = 4'h4;   // Read only

	// Control register fields
	localparam int ctrl_w           = 6;
	localparam int ctrl_psg_bit     = 0;
	localparam int ctrl_cdda_bit    = 1;
	localparam int ctrl_adpcm_bit   = 2;
	localparam int ctrl_boost_bit   = 3;
	localparam int ctrl_mode_lsb    = 4;   // Two bits wide
	localparam logic [ctrl_w-1:0] ctrl_reset_value = 6'h07;

	localparam logic [1:0] axil_resp_okay   = 2'b00;
	localparam logic [1:0] axil_resp_slverr = 2'b10;

	// Encoding 3 is not named, the hardware treats it as the 4x curve
	typedef enum logic [1:0] {
		boost_off = 2'd0,
		boost_2x  = 2'd1,
		boost_4x  = 2'd2
	} boost_mode_t;

	typedef enum logic [1:0] {
		axil_idle,
		axil_write_resp,
		axil_read_data
	} axil_state_t;

endpackage

`default_nettype wire

// File: logic/audio_ctrl_regs.sv
// AXI4-Lite slave with one transaction in flight, a write wins over a read in the same cycle
// Only byte lane 0 of the control register is writable, the sample counter wraps at 2^32
`timescale 1ns/1ps
`default_nettype none

module audio_ctrl_regs import audio_pkg::*; (
	input  wire logic                     clk_sys,
	input  wire logic                     reset,

	input  wire logic [axil_addr_w-1:0]   s_axil_awaddr,
	input  wire logic                     s_axil_awvalid,
	output logic                          s_axil_awready,
	input  wire logic [axil_data_w-1:0]   s_axil_wdata,
	input  wire logic [axil_data_w/8-1:0] s_axil_wstrb,
	input  wire logic                     s_axil_wvalid,
	output logic                          s_axil_wready,
	output logic [1:0]                    s_axil_bresp,
	output logic                          s_axil_bvalid,
	input  wire logic                     s_axil_bready,
	input  wire logic [axil_addr_w-1:0]   s_axil_araddr,
	input  wire logic                     s_axil_arvalid,
	output logic                          s_axil_arready,
	output logic [axil_data_w-1:0]        s_axil_rdata,
	output logic [1:0]                    s_axil_rresp,
	output logic                          s_axil_rvalid,
	input  wire logic                     s_axil_rready,

	input  wire logic                     sample_done,   // One pulse per output sample

	output logic                          psg_en,
	output logic                          cdda_en,
	output logic                          adpcm_en,
	output logic                          cd_boost,
	output boost_mode_t                   boost_mode
);

	axil_state_t             state, state_next;
	logic [ctrl_w-1:0]       ctrl_reg;
	logic [axil_data_w-1:0]  sample_count;
	logic                    write_req;
	logic                    write_go;
	logic                    read_go;

	////////////////////////////////////////////////////////////////////////////
	// Handshake decode

	assign write_req = s_axil_awvalid && s_axil_wvalid;   // Address and data together
	assign write_go  = (state == axil_idle) && write_req;
	assign read_go   = (state == axil_idle) && !write_req && s_axil_arvalid;

	assign s_axil_awready = write_go;
	assign s_axil_wready  = write_go;
	assign s_axil_arready = read_go;
	assign s_axil_bvalid  = (state == axil_write_resp);
	assign s_axil_rvalid  = (state == axil_read_data);

	always_comb begin
		state_next = state;
		case (state)
			axil_idle: begin
				if (write_go)
					state_next = axil_write_resp;
				else if (read_go)
					state_next = axil_read_data;
			end
			axil_write_resp: if (s_axil_bready) state_next = axil_idle;
			axil_read_data:  if (s_axil_rready) state_next = axil_idle;
			default:         state_next = axil_idle;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			state <= axil_idle;
		else
			state <= state_next;
	end

	////////////////////////////////////////////////////////////////////////////
	// Register file and responses

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ctrl_reg     <= ctrl_reset_value;
			sample_count <= '0;
		end else begin
			if (write_go && s_axil_awaddr == reg_ctrl_addr && s_axil_wstrb[0])
				ctrl_reg <= s_axil_wdata[ctrl_w-1:0];
			if (sample_done)
				sample_count <= sample_count + 1'b1;
		end
	end

	// Response payload, held while the master stalls
	always_ff @(posedge clk_sys) begin
		if (write_go)
			s_axil_bresp <= (s_axil_awaddr == reg_ctrl_addr) ? axil_resp_okay : axil_resp_slverr;

		if (read_go) begin
			case (s_axil_araddr)
				reg_ctrl_addr: begin
					s_axil_rdata <= axil_data_w'(ctrl_reg);
					s_axil_rresp <= axil_resp_okay;
				end
				reg_count_addr: begin
					s_axil_rdata <= sample_count;
					s_axil_rresp <= axil_resp_okay;
				end
				default: begin
					s_axil_rdata <= '0;
					s_axil_rresp <= axil_resp_slverr;
				end
			endcase
		end
	end

	assign psg_en     = ctrl_reg[ctrl_psg_bit];
	assign cdda_en    = ctrl_reg[ctrl_cdda_bit];
	assign adpcm_en   = ctrl_reg[ctrl_adpcm_bit];
	assign cd_boost   = ctrl_reg[ctrl_boost_bit];
	assign boost_mode = boost_mode_t'(ctrl_reg[ctrl_mode_lsb +: 2]);

	// Responses stay put until the master takes them
	assert property (@(posedge clk_sys) disable iff (reset)
		s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp));

	assert property (@(posedge clk_sys) disable iff (reset)
		s_axil_rvalid && !s_axil_rready |=>
			s_axil_rvalid && $stable(s_axil_rdata) && $stable(s_axil_rresp));

endmodule

`default_nettype wire

// File: logic/audio_source_mix.sv
// Three-stage mix of PSG, ADPCM and CD-DA, control bits are sampled with each in_valid
// Final gain wraps on overflow, the same as the console
`timescale 1ns/1ps
`default_nettype none

module audio_source_mix import audio_pkg::*; (
	input  wire logic                       clk_sys,
	input  wire logic                       reset,
	input  wire logic signed [sample_w-1:0] psg_l,
	input  wire logic signed [sample_w-1:0] psg_r,
	input  wire logic signed [sample_w-1:0] adpcm,
	input  wire logic signed [sample_w-1:0] cdda_l,
	input  wire logic signed [sample_w-1:0] cdda_r,
	input  wire logic                       in_valid,
	input  wire logic                       psg_en,
	input  wire logic                       cdda_en,
	input  wire logic                       adpcm_en,
	input  wire logic                       cd_boost,
	output logic signed [sample_w-1:0]      mix_l,
	output logic signed [sample_w-1:0]      mix_r,
	output logic                            mix_valid
);

	function automatic logic signed [mix_w-1:0] sext(input logic signed [sample_w-1:0] x);
		return {{(mix_w-sample_w){x[sample_w-1]}}, x};
	endfunction

	// Stage 1 registers
	logic signed [sample_w-1:0] psg_l_red, psg_r_red, adpcm_red;
	logic signed [sample_w-1:0] cdda_l_s1, cdda_r_s1;
	logic                       psg_en_s1, cdda_en_s1, adpcm_en_s1, cd_boost_s1;
	logic                       valid_s1;

	// Stage 2 registers
	logic signed [mix_w-1:0]    pre_l, pre_r;
	logic                       cd_boost_s2;
	logic                       valid_s2;

	logic signed [mix_w-1:0]    gain_l, gain_r;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1, level reduction
	always_ff @(posedge clk_sys) begin
		psg_l_red   <= (psg_l >>> 1) + (psg_l >>> 2) + (psg_l >>> 4);   // About 0.81
		psg_r_red   <= (psg_r >>> 1) + (psg_r >>> 2) + (psg_r >>> 4);
		adpcm_red   <= (adpcm >>> 1) + (adpcm >>> 2) + (adpcm >>> 3);   // 0.875
		cdda_l_s1   <= cdda_l;
		cdda_r_s1   <= cdda_r;
		psg_en_s1   <= psg_en;
		cdda_en_s1  <= cdda_en;
		adpcm_en_s1 <= adpcm_en;
		cd_boost_s1 <= cd_boost;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2, gating and sum
	always_ff @(posedge clk_sys) begin
		pre_l <= (cdda_en_s1                ? sext(cdda_l_s1) : '0)
			+ ((cdda_en_s1 && cd_boost_s1) ? sext(cdda_l_s1) : '0)   // Boost adds CD twice
			+ (psg_en_s1                   ? sext(psg_l_red) : '0)
			+ (adpcm_en_s1                 ? sext(adpcm_red) : '0);
		pre_r <= (cdda_en_s1                ? sext(cdda_r_s1) : '0)
			+ ((cdda_en_s1 && cd_boost_s1) ? sext(cdda_r_s1) : '0)
			+ (psg_en_s1                   ? sext(psg_r_red) : '0)
			+ (adpcm_en_s1                 ? sext(adpcm_red) : '0);
		cd_boost_s2 <= cd_boost_s1;
	end

	// Stage 3, 5/4 gain unless CD is boosted
	assign gain_l = cd_boost_s2 ? pre_l : pre_l + (pre_l >>> 2);
	assign gain_r = cd_boost_s2 ? pre_r : pre_r + (pre_r >>> 2);

	always_ff @(posedge clk_sys) begin
		mix_l <= gain_l[mix_w-1:2];
		mix_r <= gain_r[mix_w-1:2];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			valid_s1  <= 1'b0;
			valid_s2  <= 1'b0;
			mix_valid <= 1'b0;
		end else begin
			valid_s1  <= in_valid;
			valid_s2  <= valid_s1;
			mix_valid <= valid_s2;
		end
	end

endmodule

`default_nettype wire

// File: logic/audio_compressor.sv
// One-channel soft-knee compressor whose output register loads only on sample_valid
// boost_mode is taken live and not pipelined with the samples
`timescale 1ns/1ps
`default_nettype none

module audio_compressor import audio_pkg::*; (
	input  wire logic                       clk_sys,
	input  wire logic                       reset,
	input  wire logic signed [sample_w-1:0] sample_in,
	input  wire logic                       sample_valid,
	input  wire boost_mode_t                boost_mode,
	output logic signed [sample_w-1:0]      sample_out,
	output logic                            out_valid
);

	logic                neg;
	logic [sample_w-1:0] mag;
	logic [sample_w-1:0] curve_2x;
	logic [sample_w-1:0] curve_4x;
	logic [sample_w-1:0] mag_out;
	logic [sample_w-1:0] comp_out;

	////////////////////////////////////////////////////////////////////////////
	// Magnitude where -32768 stays 0x8000
	assign neg = sample_in[sample_w-1];
	assign mag = neg ? (~sample_in) + 1'b1 : sample_in;

	// Linear gain below the knee, shallow slope above it
	always_comb begin
		if (mag < comp_x_2x)
			curve_2x = mag * comp_a_2x;
		else
			curve_2x = ((mag - comp_x_2x) / comp_f_2x) + comp_b_2x;

		if (mag < comp_x_4x)
			curve_4x = mag * comp_a_4x;
		else
			curve_4x = ((mag - comp_x_4x) / comp_f_4x) + comp_b_4x;
	end

	// Anything other than 2x picks the 4x curve
	assign mag_out  = (boost_mode == boost_2x) ? curve_2x : curve_4x;
	assign comp_out = neg ? ~(mag_out - 1'b1) : mag_out;   // Sign back

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sample_out <= '0;
			out_valid  <= 1'b0;
		end else begin
			out_valid <= sample_valid;
			if (sample_valid) begin
				if (boost_mode == boost_off)
					sample_out <= sample_in;   // Bypass
				else
					sample_out <= $signed(comp_out);
			end
		end
	end

	// The curve keeps the sign of each sample through the one-cycle latency
	assert property (@(posedge clk_sys) disable iff (reset)
		sample_valid |=>
			out_valid && sample_out[sample_w-1] == $past(sample_in[sample_w-1]));

endmodule

`default_nettype wire

// File: logic/audio_mixer_top.sv
// Audio mixing path with AXI4-Lite control, fixed 4-cycle latency from in_valid to out_valid
// No back-pressure on the sample stream, a sample may enter every cycle
`timescale 1ns/1ps
`default_nettype none

module audio_mixer_top import audio_pkg::*; (
	input  wire logic                       clk_sys,
	input  wire logic                       reset,

	// AXI4-Lite control port
	input  wire logic [axil_addr_w-1:0]     s_axil_awaddr,
	input  wire logic                       s_axil_awvalid,
	output logic                            s_axil_awready,
	input  wire logic [axil_data_w-1:0]     s_axil_wdata,
	input  wire logic [axil_data_w/8-1:0]   s_axil_wstrb,
	input  wire logic                       s_axil_wvalid,
	output logic                            s_axil_wready,
	output logic [1:0]                      s_axil_bresp,
	output logic                            s_axil_bvalid,
	input  wire logic                       s_axil_bready,
	input  wire logic [axil_addr_w-1:0]     s_axil_araddr,
	input  wire logic                       s_axil_arvalid,
	output logic                            s_axil_arready,
	output logic [axil_data_w-1:0]          s_axil_rdata,
	output logic [1:0]                      s_axil_rresp,
	output logic                            s_axil_rvalid,
	input  wire logic                       s_axil_rready,

	// Sample stream
	input  wire logic signed [sample_w-1:0] psg_l,
	input  wire logic signed [sample_w-1:0] psg_r,
	input  wire logic signed [sample_w-1:0] adpcm,
	input  wire logic signed [sample_w-1:0] cdda_l,
	input  wire logic signed [sample_w-1:0] cdda_r,
	input  wire logic                       in_valid,
	output logic signed [sample_w-1:0]      audio_l,
	output logic signed [sample_w-1:0]      audio_r,
	output logic                            out_valid
);

	logic                       psg_en, cdda_en, adpcm_en, cd_boost;
	boost_mode_t                boost_mode;
	logic signed [sample_w-1:0] mix_l, mix_r;
	logic                       mix_valid;

	audio_ctrl_regs audio_ctrl_regs_inst (
		.clk_sys, .reset,
		.s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
		.s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
		.s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
		.s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
		.s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
		.sample_done (out_valid),   // Counts what leaves the mixer
		.psg_en, .cdda_en, .adpcm_en, .cd_boost, .boost_mode
	);

	audio_source_mix audio_source_mix_inst (
		.clk_sys, .reset,
		.psg_l, .psg_r, .adpcm, .cdda_l, .cdda_r, .in_valid,
		.psg_en, .cdda_en, .adpcm_en, .cd_boost,
		.mix_l, .mix_r, .mix_valid
	);

	audio_compressor compressor_l (
		.clk_sys, .reset,
		.sample_in (mix_l), .sample_valid (mix_valid), .boost_mode,
		.sample_out (audio_l), .out_valid (out_valid)
	);

	// Right valid is identical to the left one
	audio_compressor compressor_r (
		.clk_sys, .reset,
		.sample_in (mix_r), .sample_valid (mix_valid), .boost_mode,
		.sample_out (audio_r), .out_valid ()
	);

endmodule

`default_nettype wire

// File: verification/tb_audio_mixer_top.sv
// Random-stimulus testbench for the audio mixer with a sample model and AXI4-Lite tasks
// Control writes only happen while no sample is in flight
`timescale 1ns/1ps
`default_nettype none

module tb_audio_mixer_top import audio_pkg::*; ();

	logic                        clk_sys;
	logic                        reset;
	logic [axil_addr_w-1:0]      s_axil_awaddr, s_axil_araddr;
	logic                        s_axil_awvalid, s_axil_awready;
	logic [axil_data_w-1:0]      s_axil_wdata, s_axil_rdata;
	logic [axil_data_w/8-1:0]    s_axil_wstrb;
	logic                        s_axil_wvalid, s_axil_wready;
	logic [1:0]                  s_axil_bresp, s_axil_rresp;
	logic                        s_axil_bvalid, s_axil_bready;
	logic                        s_axil_arvalid, s_axil_arready;
	logic                        s_axil_rvalid, s_axil_rready;
	logic signed [sample_w-1:0]  psg_l, psg_r, adpcm, cdda_l, cdda_r;
	logic                        in_valid;
	logic signed [sample_w-1:0]  audio_l, audio_r;
	logic                        out_valid;

	integer                      seed;
	int                          errors, checked, out_count, cycle_count, timeout_count;
	logic [ctrl_w-1:0]           ctrl_model;   // Shadow of the control register
	logic [sample_w-1:0]         exp_l_q[$], exp_r_q[$];
	int                          exp_cyc_q[$];
	logic [sample_w-1:0]         exp_l, exp_r, mix_l_model, mix_r_model;
	int                          in_cycle;
	logic [sample_w-1:0]         knee_mag[6];

	audio_mixer_top audio_mixer_top_inst (.*);

	always #2 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic signed [sample_w-1:0] reduce_level(
		input logic signed [sample_w-1:0] x, input int last_shift);
		logic signed [sample_w-1:0] r;
		r = (x >>> 1) + (x >>> 2) + (x >>> last_shift);   // Truncated to 16 bits
		return r;
	endfunction

	function automatic logic [sample_w-1:0] model_mix(input logic signed [sample_w-1:0] psg,
		input logic signed [sample_w-1:0] ad, input logic signed [sample_w-1:0] cd,
		input logic [ctrl_w-1:0] ctrl);
		int          pre, gain;
		logic [31:0] gbits;
		pre = 0;
		if (ctrl[1])
			pre = pre + cd;
		if (ctrl[1] && ctrl[3])
			pre = pre + cd;                           // CD boost doubles CD-DA
		if (ctrl[0])
			pre = pre + reduce_level(psg, 4);
		if (ctrl[2])
			pre = pre + reduce_level(ad, 3);
		gain  = ctrl[3] ? pre : pre + (pre >>> 2);
		gbits = gain;
		return gbits[17:2];                          // Wraps like an 18-bit register
	endfunction

	function automatic logic [sample_w-1:0] model_compress(input logic [sample_w-1:0] s,
		input logic [1:0] mode);
		int          mag, knee, a, f, b, r;
		logic [31:0] rb;
		if (mode == 2'd0)
			return s;
		knee = (mode == 2'd1) ? comp_x_2x : comp_x_4x;
		a    = (mode == 2'd1) ? comp_a_2x : comp_a_4x;
		f    = (mode == 2'd1) ? comp_f_2x : comp_f_4x;
		b    = (mode == 2'd1) ? comp_b_2x : comp_b_4x;
		mag  = s[15] ? (65536 - s) % 65536 : s;
		if (mag < knee)
			r = mag * a;
		else
			r = (mag - knee) / f + b;
		r = r % 65536;
		if (s[15])
			r = (65536 - r) % 65536;
		rb = r;
		return rb[15:0];
	endfunction

	// Checks outputs first, then queues the sample entering this edge
	always @(posedge clk_sys) begin
		if (!reset) begin
			cycle_count++;
			if (out_valid) begin
				out_count++;
				if (exp_l_q.size() == 0) begin
					errors++;
					$display("out_valid at cycle %0d with no sample in flight", cycle_count);
				end else begin
					exp_l    = exp_l_q.pop_front();
					exp_r    = exp_r_q.pop_front();
					in_cycle = exp_cyc_q.pop_front();
					if (cycle_count - in_cycle != 4) begin
						errors++;
						$display("Sample came out %0d cycles after entering instead of 4",
							cycle_count - in_cycle);
					end
					if (audio_l !== exp_l) begin
						errors++;
						$display("CHECK FAILED audio_l expected 0x%h got 0x%h", exp_l, audio_l);
					end
					if (audio_r !== exp_r) begin
						errors++;
						$display("CHECK FAILED audio_r expected 0x%h got 0x%h", exp_r, audio_r);
					end
					checked++;
				end
			end
			if (in_valid) begin
				mix_l_model = model_mix(psg_l, adpcm, cdda_l, ctrl_model);
				mix_r_model = model_mix(psg_r, adpcm, cdda_r, ctrl_model);
				exp_l_q.push_back(model_compress(mix_l_model, ctrl_model[5:4]));
				exp_r_q.push_back(model_compress(mix_r_model, ctrl_model[5:4]));
				exp_cyc_q.push_back(cycle_count);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks

	function automatic logic [sample_w-1:0] rand16();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	task automatic drive_sample(input logic [15:0] p_l, input logic [15:0] p_r,
		input logic [15:0] ad, input logic [15:0] c_l, input logic [15:0] c_r);
		@(posedge clk_sys);
		#1;
		psg_l    = p_l;
		psg_r    = p_r;
		adpcm    = ad;
		cdda_l   = c_l;
		cdda_r   = c_r;
		in_valid = 1'b1;
	endtask

	task automatic drive_idle();
		@(posedge clk_sys);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic drain_pipeline();
		drive_idle();
		while (exp_l_q.size() != 0) begin
			@(posedge clk_sys);
			#1;
		end
		repeat (2) @(posedge clk_sys);   // Let the sample counter catch up
		#1;
	endtask

	task automatic stream_random(input int n, input bit gaps);
		int sent;
		sent = 0;
		while (sent < n) begin
			if (gaps && (rand16() & 16'h000F) == 0)
				drive_idle();
			else begin
				drive_sample(rand16(), rand16(), rand16(), rand16(), rand16());
				sent++;
			end
		end
		drain_pipeline();
	endtask

	task automatic write_register(input logic [axil_addr_w-1:0] addr,
		input logic [axil_data_w-1:0] data, input logic [3:0] strb, input logic [1:0] resp);
		logic [1:0] bresp_held;
		@(posedge clk_sys);
		#1;
		s_axil_awaddr  = addr;
		s_axil_wdata   = data;
		s_axil_wstrb   = strb;
		s_axil_awvalid = 1'b1;
		s_axil_wvalid  = 1'b1;
		@(posedge clk_sys);
		while (!s_axil_awready)
			@(posedge clk_sys);
		if (!s_axil_wready) begin
			errors++;
			$display("Write data not accepted with its address 0x%h", addr);
		end
		#1;
		s_axil_awvalid = 1'b0;
		s_axil_wvalid  = 1'b0;
		@(posedge clk_sys);
		while (!s_axil_bvalid)
			@(posedge clk_sys);
		if (s_axil_bresp !== resp) begin
			errors++;
			$display("CHECK FAILED s_axil_bresp expected 0x%h got 0x%h", resp, s_axil_bresp);
		end
		bresp_held = s_axil_bresp;
		#1;
		s_axil_bready = 1'b1;   // Response waits one cycle before it is taken
		@(posedge clk_sys);
		if (!s_axil_bvalid || s_axil_bresp !== bresp_held) begin
			errors++;
			$display("Write response dropped or changed while bready was low");
		end
		#1;
		s_axil_bready = 1'b0;
		if (addr == reg_ctrl_addr && strb[0])
			ctrl_model = data[ctrl_w-1:0];
	endtask

	task automatic read_register(input logic [axil_addr_w-1:0] addr,
		input logic [axil_data_w-1:0] data, input logic [1:0] resp);
		logic [axil_data_w-1:0] rdata_held;
		logic [1:0]             rresp_held;
		@(posedge clk_sys);
		#1;
		s_axil_araddr  = addr;
		s_axil_arvalid = 1'b1;
		@(posedge clk_sys);
		while (!s_axil_arready)
			@(posedge clk_sys);
		#1;
		s_axil_arvalid = 1'b0;
		@(posedge clk_sys);
		while (!s_axil_rvalid)
			@(posedge clk_sys);
		if (s_axil_rdata !== data) begin
			errors++;
			$display("CHECK FAILED s_axil_rdata expected 0x%h got 0x%h", data, s_axil_rdata);
		end
		if (s_axil_rresp !== resp) begin
			errors++;
			$display("CHECK FAILED s_axil_rresp expected 0x%h got 0x%h", resp, s_axil_rresp);
		end
		rdata_held = s_axil_rdata;
		rresp_held = s_axil_rresp;
		#1;
		s_axil_rready = 1'b1;   // Data waits one cycle before it is taken
		@(posedge clk_sys);
		if (!s_axil_rvalid || s_axil_rdata !== rdata_held || s_axil_rresp !== rresp_held) begin
			errors++;
			$display("Read response dropped or changed while rready was low");
		end
		#1;
		s_axil_rready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		timeout_count = 0;
		while (timeout_count < 20000) begin   // Well above the length of all tests
			@(posedge clk_sys);
			timeout_count++;
		end
		$display("Timeout after %0d cycles, errors so far %0d", timeout_count, errors);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		clk_sys = 1'b0;
		reset   = 1'b1;
		{s_axil_awaddr, s_axil_araddr, s_axil_wdata, s_axil_wstrb} = '0;
		{s_axil_awvalid, s_axil_wvalid, s_axil_bready, s_axil_arvalid, s_axil_rready} = '0;
		{psg_l, psg_r, adpcm, cdda_l, cdda_r, in_valid} = '0;
		seed       = 39;
		errors     = 0;
		checked    = 0;
		out_count  = 0;
		cycle_count = 0;
		ctrl_model = ctrl_reset_value;
		knee_mag   = '{16'd28084, 16'd28086, 16'd28088, 16'd14796, 16'd14798, 16'd14800};
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Reset values
		read_register(reg_ctrl_addr, 32'h07, axil_resp_okay);
		read_register(reg_count_addr, 32'h0, axil_resp_okay);

		stream_random(500, 1'b1);

		// Every source enable combination including all off
		for (int en = 0; en < 8; en++) begin
			write_register(reg_ctrl_addr, en, 4'h1, axil_resp_okay);
			stream_random(40, 1'b0);
		end

		// CD boost with full-scale inputs
		write_register(reg_ctrl_addr, 32'h0F, 4'h1, axil_resp_okay);
		stream_random(100, 1'b1);
		drive_sample(16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF);
		drive_sample(16'h8000, 16'h8000, 16'h8000, 16'h8000, 16'h8000);
		drive_sample(16'h7FFF, 16'h8000, 16'h7FFF, 16'h8000, 16'h7FFF);
		drain_pipeline();

		// CD only with boost puts cdda/2 on each compressor knee
		for (int mode = 1; mode < 4; mode++) begin
			write_register(reg_ctrl_addr, (mode << 4) | 32'h0A, 4'h1, axil_resp_okay);
			for (int k = 0; k < 6; k++) begin
				drive_sample(rand16(), rand16(), rand16(), knee_mag[k], ~knee_mag[k] + 16'd1);
				drive_sample(rand16(), rand16(), rand16(), ~knee_mag[k] + 16'd1, knee_mag[k]);
			end
			drive_sample(16'h8000, 16'h8000, 16'h8000, 16'h8000, 16'h7FFF);
			drain_pipeline();
			write_register(reg_ctrl_addr, (mode << 4) | 32'h07, 4'h1, axil_resp_okay);
			stream_random(100, 1'b1);
			drive_sample(16'h8000, 16'h8000, 16'h8000, 16'h8000, 16'h8000);
			drive_sample(16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF);
			drain_pipeline();
		end

		// Error responses leave the control register alone
		write_register(reg_count_addr, 32'h3F, 4'hF, axil_resp_slverr);
		read_register(4'h8, 32'h0, axil_resp_slverr);
		read_register(reg_ctrl_addr, {26'd0, ctrl_model}, axil_resp_okay);
		read_register(reg_count_addr, out_count, axil_resp_okay);

		$display("Errors: %0d, samples checked: %0d", errors, checked);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: audio_mixer_top.f
logic/audio_pkg.sv
logic/audio_ctrl_regs.sv
logic/audio_source_mix.sv
logic/audio_compressor.sv
logic/audio_mixer_top.sv
verification/tb_audio_mixer_top.sv

// File: Bender.yml
package:
  name: audio_mixer

sources:
  - logic/audio_pkg.sv
  - logic/audio_ctrl_regs.sv
  - logic/audio_source_mix.sv
  - logic/audio_compressor.sv
  - logic/audio_mixer_top.sv
  - target: test
    files:
      - verification/tb_audio_mixer_top.sv
